//--- source/decode_pkg.sv
`default_nettype none

package decode_pkg;

    // Plain widths
    typedef logic [31:0] instr_t;       // Instruction word from fetch
    typedef logic [3:0]  reg_idx_t;     // Register number
    typedef logic [15:0] imm_t;         // Immediate field
    typedef logic [4:0]  shamt_t;       // Shift amount
    typedef logic [1:0]  shdir_t;       // Shift direction

    localparam int NUM_INT_LINES = 24;  // Interrupt vector width

    typedef logic [NUM_INT_LINES-1:0] int_vec_t;

    // Instruction field positions
    localparam int OPC_HI    = 31;
    localparam int OPC_LO    = 24;
    localparam int RD_HI     = 23;
    localparam int RD_LO     = 20;
    localparam int RM_HI     = 19;
    localparam int RM_LO     = 16;
    localparam int RN_HI     = 15;
    localparam int RN_LO     = 12;
    localparam int SHAMT_HI  = 11;
    localparam int SHAMT_LO  = 7;
    localparam int SHDIR_HI  = 6;
    localparam int SHDIR_LO  = 5;
    localparam int IMM_HI    = 15;
    localparam int IMM_LO    = 0;

    // Opcode bit 4 marks the immediate form of the ALU groups
    localparam int OPC_IMM_BIT = 28;

    typedef enum logic [7:0] {
        OP_LDRI   = 8'h10,              // Rd <- [Rm + imm]
        OP_STRI   = 8'h30,              // [Rm + imm] <- Rd
        OP_MOVI   = 8'h24,              // Rd <- imm
        OP_ADD    = 8'h40,
        OP_ADDC   = 8'h41,
        OP_SUB    = 8'h42,
        OP_RSUB   = 8'h43,
        OP_SUBC   = 8'h44,
        OP_RSUBC  = 8'h45,
        OP_ADDI   = 8'h50,
        OP_ADDIC  = 8'h51,
        OP_SUBI   = 8'h52,
        OP_RSUBI  = 8'h53,
        OP_SUBIC  = 8'h54,
        OP_RSUBIC = 8'h55,
        OP_AND    = 8'h60,
        OP_BIC    = 8'h61,
        OP_OR     = 8'h62,
        OP_XOR    = 8'h63,
        OP_ANDI   = 8'h70,
        OP_BICI   = 8'h71,
        OP_ORI    = 8'h72,
        OP_XORI   = 8'h73,
        OP_CMP    = 8'h68,              // Flags from Rm - sh(Rn)
        OP_TST    = 8'h69,              // Flags from Rm & sh(Rn)
        OP_CMPI   = 8'h78,
        OP_TSTI   = 8'h79,
        OP_INT    = 8'hF0               // Software interrupt
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_BIC,
        ALU_OR,
        ALU_XOR,
        ALU_MOV
    } alu_op_t;

    typedef enum logic [1:0] {
        DEST_NONE,                      // Flags only
        DEST_REG,                       // Write Rd
        DEST_LOAD,                      // Memory read into Rd
        DEST_STORE                      // Memory write of Rd
    } dest_t;

    typedef enum logic {
        OPND_REG,                       // Shifted Rn
        OPND_IMM                        // Immediate field
    } opnd_t;

    // Control bundle handed to execute
    typedef struct packed {
        alu_op_t  alu_op;
        dest_t    dest;
        opnd_t    opnd;
        logic     reverse;              // Swap ALU operands
        logic     set_flags;
        shamt_t   shamt;
        shdir_t   shdir;
        imm_t     imm;
        reg_idx_t rd;
        reg_idx_t rm;
        reg_idx_t rn;
    } exec_ctl_t;

    typedef struct packed {
        logic take;                     // Word needs an interrupt
        logic undefined;                // Opcode not in the table
        imm_t vector;
    } trap_t;

endpackage

`default_nettype wire

//--- source/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
    import decode_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire instr_t instr,
    input  wire logic  load,
    output trap_t      trap,
    output exec_ctl_t  ctl
);

    opcode_t   opcode;
    exec_ctl_t dec;
    logic      defined;
    logic      is_int;
    exec_ctl_t ctl_q;

    assign opcode = opcode_t'(instr[OPC_HI:OPC_LO]);

    always_comb begin
        dec           = '0;
        dec.rd        = instr[RD_HI:RD_LO];
        dec.rm        = instr[RM_HI:RM_LO];
        dec.rn        = instr[RN_HI:RN_LO];
        dec.shdir     = instr[SHDIR_HI:SHDIR_LO];
        dec.opnd      = opnd_t'(instr[OPC_IMM_BIT]); // ALU groups only
        dec.alu_op    = ALU_ADD;
        dec.dest      = DEST_REG;
        dec.reverse   = 1'b0;
        dec.set_flags = 1'b1;
        defined       = 1'b1;
        is_int        = 1'b0;

        case (opcode)
            OP_LDRI: begin
                dec.opnd      = OPND_IMM;
                dec.dest      = DEST_LOAD;
                dec.set_flags = 1'b0;
            end
            OP_STRI: begin
                dec.opnd      = OPND_IMM;
                dec.dest      = DEST_STORE;
                dec.set_flags = 1'b0;
            end
            OP_MOVI: begin
                dec.opnd      = OPND_IMM;
                dec.alu_op    = ALU_MOV;
                dec.set_flags = 1'b0;
            end
            OP_ADD, OP_ADDI: begin
                dec.alu_op = ALU_ADD;
            end
            OP_ADDC, OP_ADDIC: begin
                dec.alu_op = ALU_ADC;
            end
            OP_SUB, OP_SUBI: begin
                dec.alu_op = ALU_SUB;
            end
            OP_RSUB, OP_RSUBI: begin
                dec.alu_op  = ALU_SUB;
                dec.reverse = 1'b1;     // Operand minus Rm
            end
            OP_SUBC, OP_SUBIC: begin
                dec.alu_op = ALU_SBC;
            end
            OP_RSUBC, OP_RSUBIC: begin
                dec.alu_op  = ALU_SBC;
                dec.reverse = 1'b1;
            end
            OP_AND, OP_ANDI: begin
                dec.alu_op = ALU_AND;
            end
            OP_BIC, OP_BICI: begin
                dec.alu_op = ALU_BIC;
            end
            OP_OR, OP_ORI: begin
                dec.alu_op = ALU_OR;
            end
            OP_XOR, OP_XORI: begin
                dec.alu_op = ALU_XOR;
            end
            OP_CMP, OP_CMPI: begin
                dec.alu_op = ALU_SUB;
                dec.dest   = DEST_NONE; // Result dropped
            end
            OP_TST, OP_TSTI: begin
                dec.alu_op = ALU_AND;
                dec.dest   = DEST_NONE;
            end
            OP_INT: begin
                is_int = 1'b1;
            end
            default: begin
                defined = 1'b0;
            end
        endcase

        // Shift amount and immediate are mutually exclusive
        if (dec.opnd == OPND_IMM) begin
            dec.shamt = '0;
            dec.imm   = instr[IMM_HI:IMM_LO];
        end else begin
            dec.shamt = instr[SHAMT_HI:SHAMT_LO];
            dec.imm   = '0;
        end
    end

    always_comb begin
        trap.take      = is_int || !defined;
        trap.undefined = !defined;
        trap.vector    = is_int ? instr[IMM_HI:IMM_LO] : '0; // Undefined maps to 0
    end

    // Bundle register for execute
    always_ff @(posedge clk) begin
        if (load && !reset) begin
            ctl_q <= dec;
        end
    end

    assign ctl = ctl_q;

endmodule

`default_nettype wire

//--- source/stage_flow.sv
`timescale 1ns/1ps
`default_nettype none

module stage_flow
    import decode_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  instr_req,
    input  wire logic  exec_rdy,
    input  wire trap_t trap,
    input  wire logic  int_fire,
    output logic       instr_rdy,
    output logic       exec_req,
    output logic       load,
    output logic       trap_load,
    output logic       drained
);

    logic exec_req_q;                   // Bundle waiting for execute
    logic halt_q;                       // Trap in flight
    logic accept;

    // Empty or emptying this cycle, and not halted
    assign instr_rdy = !halt_q && (!exec_req_q || exec_rdy);
    assign accept    = instr_req && instr_rdy;
    assign load      = accept && !trap.take;
    assign trap_load = accept && trap.take;
    assign exec_req  = exec_req_q;
    assign drained   = !exec_req_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            exec_req_q <= 1'b0;
        end else if (load) begin
            exec_req_q <= 1'b1;
        end else if (exec_rdy) begin
            exec_req_q <= 1'b0;         // Taken by execute
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            halt_q <= 1'b0;
        end else if (trap_load) begin
            halt_q <= 1'b1;
        end else if (int_fire) begin
            halt_q <= 1'b0;             // Released after the pulse cycle
        end
    end

endmodule

`default_nettype wire

//--- source/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl
    import decode_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire trap_t trap,
    input  wire logic  trap_load,
    input  wire logic  drained,
    input  wire logic  exec_rdy,
    output logic       int_fire,
    output int_vec_t   int_line
);

    logic pending_q;
    logic undef_q;
    imm_t vector_q;
    logic fire_q;
    int_vec_t line_sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= 1'b0;
            fire_q    <= 1'b0;
        end else begin
            fire_q <= pending_q && drained && exec_rdy;
            if (trap_load) begin
                pending_q <= 1'b1;
            end else if (pending_q && drained && exec_rdy) begin
                pending_q <= 1'b0;      // Fires next cycle
            end
        end
    end

    // Trap details for the line decode
    always_ff @(posedge clk) begin
        if (trap_load) begin
            undef_q  <= trap.undefined;
            vector_q <= trap.vector;
        end
    end

    // Vectors past the last line select nothing
    always_comb begin
        line_sel = '0;
        for (int i = 0; i < NUM_INT_LINES; i++) begin
            if (vector_q == imm_t'(i)) begin
                line_sel[i] = 1'b1;
            end
        end
        if (undef_q) begin
            line_sel = int_vec_t'(1); // Undefined opcode always on line 0
        end
    end

    assign int_fire = fire_q;
    assign int_line = fire_q ? line_sel : '0;

endmodule

`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import decode_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire instr_t instr,          // From fetch
    input  wire logic   instr_req,
    output logic        instr_rdy,
    output exec_ctl_t   ctl,            // To execute
    output logic        exec_req,
    input  wire logic   exec_rdy,
    output int_vec_t    int_line
);

    trap_t trap;
    logic  load;
    logic  trap_load;
    logic  drained;
    logic  int_fire;

    instr_decoder u_decoder (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .load  (load),
        .trap  (trap),
        .ctl   (ctl)
    );

    stage_flow u_flow (
        .clk       (clk),
        .reset     (reset),
        .instr_req (instr_req),
        .exec_rdy  (exec_rdy),
        .trap      (trap),
        .int_fire  (int_fire),
        .instr_rdy (instr_rdy),
        .exec_req  (exec_req),
        .load      (load),
        .trap_load (trap_load),
        .drained   (drained)
    );

    trap_ctrl u_trap (
        .clk       (clk),
        .reset     (reset),
        .trap      (trap),
        .trap_load (trap_load),
        .drained   (drained),
        .exec_rdy  (exec_rdy),
        .int_fire  (int_fire),
        .int_line  (int_line)
    );

endmodule

`default_nettype wire

//--- verif/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Bit 4 of the opcode picks the immediate form in the ALU groups
function automatic bit opc_defined(input logic [7:0] op);
    case (op[7:4])
        4'h1, 4'h3, 4'hF: return op[3:0] == 4'h0;
        4'h2:             return op[3:0] == 4'h4;
        4'h4, 4'h5:       return op[3:0] <= 4'h5;
        4'h6, 4'h7:       return op[3:0] <= 4'h3 || op[3:0] == 4'h8 || op[3:0] == 4'h9;
        default:          return 1'b0;
    endcase
endfunction

function automatic bit is_trap_word(input instr_t w);
    return !opc_defined(w[31:24]) || w[31:24] == 8'hF0;
endfunction

// Expected bundle for a defined, non-INT word
function automatic exec_ctl_t model_ctl(input instr_t w);
    exec_ctl_t  c;
    logic [7:0] op;
    op          = w[31:24];
    c           = '0;
    c.rd        = w[23:20];
    c.rm        = w[19:16];
    c.rn        = w[15:12];
    c.shdir     = w[6:5];
    c.alu_op    = ALU_ADD;              // Address add for loads and stores
    c.dest      = DEST_REG;
    c.set_flags = op >= 8'h40;          // Only the ALU groups touch flags
    c.opnd      = (op < 8'h40 || op[4]) ? OPND_IMM : OPND_REG;
    if (op == 8'h10)
        c.dest = DEST_LOAD;
    if (op == 8'h30)
        c.dest = DEST_STORE;
    if (op == 8'h24)
        c.alu_op = ALU_MOV;
    if (op[7:5] == 3'b010) begin        // Arithmetic
        case (op[3:0])
            4'h0:       c.alu_op = ALU_ADD;
            4'h1:       c.alu_op = ALU_ADC;
            4'h2, 4'h3: c.alu_op = ALU_SUB;
            default:    c.alu_op = ALU_SBC;
        endcase
        c.reverse = op[3:0] == 4'h3 || op[3:0] == 4'h5;
    end
    if (op[7:5] == 3'b011) begin        // Logic, compare and test
        case (op[3:0])
            4'h0, 4'h9: c.alu_op = ALU_AND;
            4'h1:       c.alu_op = ALU_BIC;
            4'h2:       c.alu_op = ALU_OR;
            4'h3:       c.alu_op = ALU_XOR;
            default:    c.alu_op = ALU_SUB;
        endcase
        if (op[3])
            c.dest = DEST_NONE;         // CMP and TST keep flags only
    end
    if (c.opnd == OPND_IMM)
        c.imm = w[15:0];
    else
        c.shamt = w[11:7];
    return c;
endfunction

// Interrupt line of a trap word
function automatic int_vec_t model_line(input instr_t w);
    int vec;
    vec = int'(w[15:0]);
    if (!opc_defined(w[31:24]))
        return int_vec_t'(1);
    if (vec >= NUM_INT_LINES)
        return '0;
    return int_vec_t'(1) << vec;
endfunction

`endif

//--- verif/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb
    import decode_pkg::*;
();

    localparam int TIMEOUT   = 200;     // Cycles per wait
    localparam int NUM_WORDS = 300;
    localparam int NUM_TRAPS = 40;

    logic      clk;
    logic      reset;
    instr_t    instr;
    logic      instr_req;
    logic      instr_rdy;
    exec_ctl_t ctl;
    logic      exec_req;
    logic      exec_rdy;
    int_vec_t  int_line;

    string      test_name = "reset";
    int         errors = 0;
    int         checks = 0;
    int         tests = 0;
    int         first_error = 0;
    bit         timed_out = 1'b0;
    bit         bp_on;                  // Random execute stalls
    logic [7:0] def_ops[$];
    logic [7:0] undef_ops[$];

    exec_ctl_t exp_q[$];                // Bundle the stage should hold
    bit        pend_m;
    bit        halt_m;
    bit        fire_m;
    int_vec_t  line_m;

    `include "decode_model.svh"

    decode_stage dut (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .instr_req (instr_req),
        .instr_rdy (instr_rdy),
        .ctl       (ctl),
        .exec_req  (exec_req),
        .exec_rdy  (exec_rdy),
        .int_line  (int_line)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        exec_rdy = 1'b1;
        forever begin
            @(posedge clk);
            exec_rdy <= bp_on ? ($urandom_range(0, 2) != 0) : 1'b1;
        end
    end

    task automatic check_ctl(input string what, input exec_ctl_t exp, input exec_ctl_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_int(input string what, input int_vec_t exp, input int_vec_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s %s expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    // Cycle model of the stage checked on every edge after reset
    always @(posedge clk) begin : model_check
        logic exp_rdy;
        logic next_fire;
        if (reset) begin
            exp_q.delete();
            pend_m = 1'b0;
            halt_m = 1'b0;
            fire_m = 1'b0;
        end else begin
            exp_rdy = !halt_m && (exp_q.size() == 0 || exec_rdy);
            check_bit("exec_req", exp_q.size() != 0, exec_req);
            check_bit("instr_rdy", exp_rdy, instr_rdy);
            check_int("int_line", fire_m ? line_m : '0, int_line);
            if (exp_q.size() != 0)
                check_ctl("ctl", exp_q[0], ctl);
            next_fire = pend_m && exp_q.size() == 0 && exec_rdy;
            if (next_fire)
                pend_m = 1'b0;
            if (fire_m)
                halt_m = 1'b0;          // Halt ends with the pulse cycle
            fire_m = next_fire;
            if (exp_q.size() != 0 && exec_rdy)
                void'(exp_q.pop_front());
            if (instr_req && exp_rdy) begin
                if (is_trap_word(instr)) begin
                    pend_m = 1'b1;
                    halt_m = 1'b1;
                    line_m = model_line(instr);
                end else begin
                    exp_q.push_back(model_ctl(instr));
                end
            end
        end
    end

    function automatic instr_t word_with(input logic [7:0] op);
        instr_t w;
        w        = instr_t'($urandom());
        w[31:24] = op;
        return w;
    endfunction

    task automatic send_word(input instr_t w);
        int n;
        if (timed_out)
            return;
        instr     <= w;
        instr_req <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!instr_rdy && n < TIMEOUT);
        if (!instr_rdy) begin
            timed_out = 1'b1;
            $display("Timeout in %s: word %h was never accepted", test_name, w);
        end else if ($urandom_range(0, 3) == 0) begin
            instr_req <= 1'b0;          // Fetch bubble
            instr     <= instr_t'($urandom());
            @(posedge clk);
        end
    endtask

    task automatic wait_idle();
        int n;
        if (timed_out)
            return;
        instr_req <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while ((exec_req || !instr_rdy) && n < TIMEOUT);
        if (exec_req || !instr_rdy) begin
            timed_out = 1'b1;
            $display("Timeout in %s: the stage never went idle", test_name);
        end
    endtask

    task automatic start_test(input string name, input bit bp);
        test_name   = name;
        bp_on      <= bp;
        first_error = errors;
    endtask

    task automatic finish_test();
        wait_idle();
        tests++;
        $display("test %s: %s (%0d errors)", test_name,
                 (errors == first_error && !timed_out) ? "passed" : "failed",
                 errors - first_error);
    endtask

    initial begin
        instr_t w;
        void'($urandom(32'h15c6_35d6));
        reset     = 1'b1;
        instr     = '0;
        instr_req = 1'b0;
        bp_on     = 1'b0;
        for (int i = 0; i < 256; i++) begin
            if (!opc_defined(i[7:0]))
                undef_ops.push_back(i[7:0]);
            else if (i[7:0] != 8'hF0)
                def_ops.push_back(i[7:0]);
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        start_test("reset", 1'b0);
        repeat (2) @(posedge clk);
        finish_test();

        start_test("stream", 1'b0);
        repeat (NUM_WORDS) send_word(word_with(def_ops[$urandom_range(0, def_ops.size() - 1)]));
        finish_test();

        start_test("backpressure", 1'b1);
        repeat (NUM_WORDS) send_word(word_with(def_ops[$urandom_range(0, def_ops.size() - 1)]));
        finish_test();

        start_test("int", 1'b1);
        repeat (NUM_TRAPS) begin
            w        = word_with(8'hF0);
            w[15:0]  = imm_t'($urandom_range(0, 31));
            send_word(w);
            send_word(word_with(def_ops[$urandom_range(0, def_ops.size() - 1)]));
        end
        finish_test();

        start_test("undefined", 1'b1);
        repeat (NUM_TRAPS) begin
            send_word(word_with(undef_ops[$urandom_range(0, undef_ops.size() - 1)]));
            send_word(word_with(def_ops[$urandom_range(0, def_ops.size() - 1)]));
        end
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !timed_out)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verif
source/decode_pkg.sv
source/instr_decoder.sv
source/stage_flow.sv
source/trap_ctrl.sv
source/decode_stage.sv
verif/decode_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module decode_stage_tb -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vdecode_stage_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
